// ==== lsu_pkg.sv ====
// shared LSU types; QUEUE_DEPTH must stay a power of two, since slot indices wrap naturally
package lsu_pkg;

    // ========================================================================
    // widths and queue sizing
    // ========================================================================
    localparam int QUEUE_DEPTH = 8;

    typedef logic [31:0]                    word_t;
    typedef logic [3:0]                     strb_t;
    typedef logic [4:0]                     reg_addr_t;
    typedef logic [3:0]                     commit_id_t;
    typedef logic [$clog2(QUEUE_DEPTH)-1:0] slot_idx_t;
    typedef logic [$clog2(QUEUE_DEPTH):0]   count_t;
    typedef logic [QUEUE_DEPTH-1:0]         slot_vec_t;

    // op encoding, loads first
    typedef enum logic [2:0] {
        LB  = 3'd0,
        LH  = 3'd1,
        LW  = 3'd2,
        LBU = 3'd3,
        LHU = 3'd4,
        SB  = 3'd5,
        SH  = 3'd6,
        SW  = 3'd7
    } mem_op_e;

    // ========================================================================
    // payload structs
    // ========================================================================
    // wdata and wmask arrive already placed in their byte lanes
    typedef struct packed {
        mem_op_e    op;
        word_t      addr;
        word_t      wdata;
        strb_t      wmask;
        reg_addr_t  rd;
        commit_id_t commit_id;
        logic       reg_we;
    } lsu_req_t;

    typedef struct packed {
        word_t      data;
        reg_addr_t  rd;
        commit_id_t commit_id;
        logic       reg_we;
    } lsu_wb_t;

    // shared by AR and AW
    typedef struct packed {
        word_t      addr;
        logic [2:0] size;
    } axi_addr_t;

    typedef struct packed {
        word_t data;
        strb_t strb;
    } axi_wdata_t;

    function automatic logic op_is_store(mem_op_e op);
        return op inside {SB, SH, SW};
    endfunction

    // AXI size code, log2 of the byte count
    function automatic logic [2:0] op_size(mem_op_e op);
        case (op)
            LB, LBU, SB: return 3'd0;
            LH, LHU, SH: return 3'd1;
            default:     return 3'd2;
        endcase
    endfunction

endpackage

// ==== lsu_load_align.sv ====
// load lane select and extend; misaligned half-words are not detected, offset bit 0 is ignored
`timescale 1ns/1ps

module lsu_load_align (
    input  lsu_pkg::mem_op_e op_i,
    input  logic [1:0]       offset_i,
    input  lsu_pkg::word_t   word_i,
    output lsu_pkg::word_t   data_o
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    // lanes picked by the low address bits
    assign byte_sel = word_i[{offset_i, 3'b000} +: 8];
    assign half_sel = offset_i[1] ? word_i[31:16] : word_i[15:0];

    always_comb begin
        case (op_i)
            lsu_pkg::LB:  data_o = {{24{byte_sel[7]}}, byte_sel};
            lsu_pkg::LBU: data_o = {24'b0, byte_sel};
            lsu_pkg::LH:  data_o = {{16{half_sel[15]}}, half_sel};
            lsu_pkg::LHU: data_o = {16'b0, half_sel};
            // LW, and stores which never reach here
            default:      data_o = word_i;
        endcase
    end

endmodule

// ==== lsu_slot_store.sv ====
// per-slot payload registers; simultaneous writes to one slot resolve to port 0
`timescale 1ns/1ps

module lsu_slot_store #(
    parameter type payload_t = lsu_pkg::word_t,
    parameter int  NUM_WR    = 1
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [NUM_WR-1:0]  we_i,
    input  lsu_pkg::slot_idx_t idx_i   [NUM_WR],
    input  payload_t           data_i  [NUM_WR],
    output payload_t           slots_o [lsu_pkg::QUEUE_DEPTH]
);

    payload_t mem_q [lsu_pkg::QUEUE_DEPTH];

    // highest port first so port 0 lands last
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < lsu_pkg::QUEUE_DEPTH; s++) begin
                mem_q[s] <= '0;
            end
        end else begin
            for (int p = NUM_WR - 1; p >= 0; p--) begin
                if (we_i[p]) begin
                    mem_q[idx_i[p]] <= data_i[p];
                end
            end
        end
    end

    // all slots visible at once
    assign slots_o = mem_q;

endmodule

// ==== lsu_fwd_match.sv ====
// store-to-load forwarding; only forwards when the youngest overlapping store covers every load byte
`timescale 1ns/1ps

module lsu_fwd_match (
    input  logic               req_valid_i,
    input  lsu_pkg::lsu_req_t  req_i,
    input  lsu_pkg::lsu_req_t  slots_i [lsu_pkg::QUEUE_DEPTH],
    input  lsu_pkg::slot_vec_t slot_valid_i,
    input  lsu_pkg::slot_idx_t head_i,
    output logic               hit_o,
    output lsu_pkg::word_t     data_o
);

    lsu_pkg::strb_t     need;
    lsu_pkg::slot_idx_t hit_idx;
    logic               hit;

    // bytes the load reads
    always_comb begin
        case (lsu_pkg::op_size(req_i.op))
            3'd0:    need = 4'b0001 << req_i.addr[1:0];
            3'd1:    need = 4'b0011 << req_i.addr[1:0];
            default: need = 4'b1111;
        endcase
    end

    // walk oldest to youngest, the last overlapping store decides
    always_comb begin
        lsu_pkg::slot_idx_t idx;
        hit     = 1'b0;
        hit_idx = '0;
        for (int i = 0; i < lsu_pkg::QUEUE_DEPTH; i++) begin
            idx = head_i + lsu_pkg::slot_idx_t'(i);
            if (slot_valid_i[idx] && lsu_pkg::op_is_store(slots_i[idx].op) &&
                slots_i[idx].addr[31:2] == req_i.addr[31:2] &&
                |(slots_i[idx].wmask & need)) begin
                hit     = (slots_i[idx].addr == req_i.addr) &&
                          ((slots_i[idx].wmask & need) == need);
                hit_idx = idx;
            end
        end
    end

    assign hit_o = req_valid_i && !lsu_pkg::op_is_store(req_i.op) && hit;

    lsu_load_align fwd_align_inst (
        .op_i     (req_i.op),
        .offset_i (req_i.addr[1:0]),
        .word_i   (slots_i[hit_idx].wdata),
        .data_o   (data_o)
    );

endmodule

// ==== lsu_ctrl.sv ====
// LSU sequencing; loads and stores never pass each other, so same-address ordering holds on the bus
`timescale 1ns/1ps

module lsu_ctrl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req_valid_i,
    input  lsu_pkg::lsu_req_t    req_i,
    output logic                 stall_o,
    output logic                 busy_o,
    output logic                 wb_valid_o,
    output lsu_pkg::lsu_wb_t     wb_o,
    input  logic                 wb_ready_i,
    input  logic                 fwd_hit_i,
    input  lsu_pkg::lsu_req_t    slots_i   [lsu_pkg::QUEUE_DEPTH],
    input  lsu_pkg::word_t       results_i [lsu_pkg::QUEUE_DEPTH],
    output lsu_pkg::slot_idx_t   head_o,
    output lsu_pkg::slot_idx_t   tail_o,
    output lsu_pkg::slot_idx_t   rd_idx_o,
    output logic                 enq_o,
    output lsu_pkg::slot_vec_t   slot_valid_o,
    output logic                 resp_we_o,
    output lsu_pkg::word_t       resp_data_o,
    output logic                 ar_valid_o,
    output lsu_pkg::axi_addr_t   ar_o,
    input  logic                 ar_ready_i,
    input  logic                 r_valid_i,
    input  lsu_pkg::word_t       r_data_i,
    output logic                 r_ready_o,
    output logic                 aw_valid_o,
    output lsu_pkg::axi_addr_t   aw_o,
    input  logic                 aw_ready_i,
    output logic                 w_valid_o,
    output lsu_pkg::axi_wdata_t  w_o,
    input  logic                 w_ready_i,
    input  logic                 b_valid_i,
    output logic                 b_ready_o
);

    typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_DATA} rd_state_e;
    typedef enum logic [1:0] {WR_IDLE, WR_ADDR, WR_DATA, WR_RESP} wr_state_e;

    lsu_pkg::slot_idx_t head, tail, rd_idx, wr_idx, rd_pick, wr_pick;
    lsu_pkg::count_t    count;
    lsu_pkg::slot_vec_t slot_valid, slot_sent, slot_done;
    lsu_pkg::lsu_req_t  head_req;
    rd_state_e          rd_state;
    wr_state_e          wr_state;
    logic               enq, retire, head_store, rd_found, wr_found;

    // ========================================================================
    // queue bookkeeping
    // ========================================================================
    assign enq     = req_valid_i && (count != lsu_pkg::QUEUE_DEPTH);
    assign stall_o = req_valid_i && (count == lsu_pkg::QUEUE_DEPTH);
    assign busy_o  = (count != '0) || (rd_state != RD_IDLE) || (wr_state != WR_IDLE);

    assign head_req   = slots_i[head];
    assign head_store = lsu_pkg::op_is_store(head_req.op);

    // finished load waits for the consumer, finished store just leaves
    assign wb_valid_o = slot_valid[head] && slot_done[head] && !head_store;
    assign retire     = slot_valid[head] && slot_done[head] && (head_store || wb_ready_i);
    assign wb_o       = '{data: results_i[head], rd: head_req.rd,
                          commit_id: head_req.commit_id, reg_we: head_req.reg_we};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head       <= '0;
            tail       <= '0;
            count      <= '0;
            slot_valid <= '0;
            slot_sent  <= '0;
            slot_done  <= '0;
        end else begin
            if (enq) begin
                slot_valid[tail] <= 1'b1;
                slot_sent[tail]  <= 1'b0;
                // forwarded load is complete on entry
                slot_done[tail]  <= fwd_hit_i && !lsu_pkg::op_is_store(req_i.op);
                tail             <= tail + 1'b1;
            end
            if (retire) begin
                slot_valid[head] <= 1'b0;
                head             <= head + 1'b1;
            end
            if (ar_valid_o && ar_ready_i) begin
                slot_sent[rd_idx] <= 1'b1;
            end
            if (aw_valid_o && aw_ready_i) begin
                slot_sent[wr_idx] <= 1'b1;
            end
            if (resp_we_o) begin
                slot_done[rd_idx] <= 1'b1;
            end
            if (b_valid_i && b_ready_o) begin
                slot_done[wr_idx] <= 1'b1;
            end
            count <= count + lsu_pkg::count_t'(enq) - lsu_pkg::count_t'(retire);
        end
    end

    // oldest pending load and store, each blocked by an older entry of the other kind
    always_comb begin
        lsu_pkg::slot_idx_t idx;
        logic               older_store;
        logic               older_load;
        rd_found    = 1'b0;
        wr_found    = 1'b0;
        rd_pick     = '0;
        wr_pick     = '0;
        older_store = 1'b0;
        older_load  = 1'b0;
        for (int i = 0; i < lsu_pkg::QUEUE_DEPTH; i++) begin
            idx = head + lsu_pkg::slot_idx_t'(i);
            if (slot_valid[idx]) begin
                if (lsu_pkg::op_is_store(slots_i[idx].op)) begin
                    if (!slot_sent[idx] && !wr_found && !older_load) begin
                        wr_found = 1'b1;
                        wr_pick  = idx;
                    end
                    older_store = 1'b1;
                end else begin
                    if (!slot_sent[idx] && !slot_done[idx] && !rd_found && !older_store) begin
                        rd_found = 1'b1;
                        rd_pick  = idx;
                    end
                    older_load = older_load || !slot_done[idx];
                end
            end
        end
    end

    // ========================================================================
    // read channel, AR then R
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_state <= RD_IDLE;
            rd_idx   <= '0;
        end else begin
            case (rd_state)
                RD_IDLE: if (rd_found) begin
                    rd_idx   <= rd_pick;
                    rd_state <= RD_ADDR;
                end
                RD_ADDR: if (ar_ready_i) rd_state <= RD_DATA;
                RD_DATA: if (r_valid_i) rd_state <= RD_IDLE;
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    assign ar_valid_o = (rd_state == RD_ADDR);
    assign ar_o       = '{addr: slots_i[rd_idx].addr, size: lsu_pkg::op_size(slots_i[rd_idx].op)};
    assign r_ready_o  = (rd_state == RD_DATA);
    assign resp_we_o  = r_valid_i && r_ready_o;

    lsu_load_align resp_align_inst (
        .op_i     (slots_i[rd_idx].op),
        .offset_i (slots_i[rd_idx].addr[1:0]),
        .word_i   (r_data_i),
        .data_o   (resp_data_o)
    );

    // ========================================================================
    // write channel, AW then W then B
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_state <= WR_IDLE;
            wr_idx   <= '0;
        end else begin
            case (wr_state)
                WR_IDLE: if (wr_found) begin
                    wr_idx   <= wr_pick;
                    wr_state <= WR_ADDR;
                end
                WR_ADDR: if (aw_ready_i) wr_state <= WR_DATA;
                WR_DATA: if (w_ready_i) wr_state <= WR_RESP;
                WR_RESP: if (b_valid_i) wr_state <= WR_IDLE;
                default: wr_state <= WR_IDLE;
            endcase
        end
    end

    assign aw_valid_o = (wr_state == WR_ADDR);
    assign aw_o       = '{addr: slots_i[wr_idx].addr, size: lsu_pkg::op_size(slots_i[wr_idx].op)};
    assign w_valid_o  = (wr_state == WR_DATA);
    assign w_o        = '{data: slots_i[wr_idx].wdata, strb: slots_i[wr_idx].wmask};
    assign b_ready_o  = (wr_state == WR_RESP);

    assign head_o       = head;
    assign tail_o       = tail;
    assign rd_idx_o     = rd_idx;
    assign enq_o        = enq;
    assign slot_valid_o = slot_valid;

endmodule

// ==== lsu_top.sv ====
// load/store unit top; single-beat AXI only, RRESP and BRESP are not observed
`timescale 1ns/1ps

module lsu_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req_valid_i,
    input  lsu_pkg::lsu_req_t    req_i,
    output logic                 stall_o,
    output logic                 busy_o,
    output logic                 wb_valid_o,
    output lsu_pkg::lsu_wb_t     wb_o,
    input  logic                 wb_ready_i,
    output logic                 ar_valid_o,
    output lsu_pkg::axi_addr_t   ar_o,
    input  logic                 ar_ready_i,
    input  logic                 r_valid_i,
    input  lsu_pkg::word_t       r_data_i,
    output logic                 r_ready_o,
    output logic                 aw_valid_o,
    output lsu_pkg::axi_addr_t   aw_o,
    input  logic                 aw_ready_i,
    output logic                 w_valid_o,
    output lsu_pkg::axi_wdata_t  w_o,
    input  logic                 w_ready_i,
    input  logic                 b_valid_i,
    output logic                 b_ready_o
);

    lsu_pkg::slot_idx_t head, tail, rd_idx;
    lsu_pkg::slot_vec_t slot_valid;
    lsu_pkg::word_t     resp_data, fwd_data;
    logic               enq, resp_we, fwd_hit;

    lsu_pkg::lsu_req_t  req_slots   [lsu_pkg::QUEUE_DEPTH];
    lsu_pkg::word_t     results     [lsu_pkg::QUEUE_DEPTH];
    lsu_pkg::slot_idx_t req_wr_idx  [1];
    lsu_pkg::lsu_req_t  req_wr_data [1];
    lsu_pkg::slot_idx_t res_wr_idx  [2];
    lsu_pkg::word_t     res_wr_data [2];

    // port 0 takes forwarded data at enqueue, port 1 takes read responses
    assign req_wr_idx[0]  = tail;
    assign req_wr_data[0] = req_i;
    assign res_wr_idx[0]  = tail;
    assign res_wr_data[0] = fwd_data;
    assign res_wr_idx[1]  = rd_idx;
    assign res_wr_data[1] = resp_data;

    // remaining ports connect by name to the top ports
    lsu_ctrl ctrl_inst (
        .*,
        .fwd_hit_i    (fwd_hit),
        .slots_i      (req_slots),
        .results_i    (results),
        .head_o       (head),
        .tail_o       (tail),
        .rd_idx_o     (rd_idx),
        .enq_o        (enq),
        .slot_valid_o (slot_valid),
        .resp_we_o    (resp_we),
        .resp_data_o  (resp_data)
    );

    lsu_slot_store #(.payload_t(lsu_pkg::lsu_req_t), .NUM_WR(1)) req_store_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .we_i    (enq),
        .idx_i   (req_wr_idx),
        .data_i  (req_wr_data),
        .slots_o (req_slots)
    );

    lsu_slot_store #(.payload_t(lsu_pkg::word_t), .NUM_WR(2)) result_store_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .we_i    ({resp_we, enq && fwd_hit}),
        .idx_i   (res_wr_idx),
        .data_i  (res_wr_data),
        .slots_o (results)
    );

    lsu_fwd_match fwd_match_inst (
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .slots_i      (req_slots),
        .slot_valid_i (slot_valid),
        .head_i       (head),
        .hit_o        (fwd_hit),
        .data_o       (fwd_data)
    );

endmodule

// ==== lsu_tb_clk.sv ====
// free-running testbench clock; fixed 100 ns period, starts low at time zero
`timescale 1ns/1ps

module lsu_tb_clk (
    output logic clk_o
);

    // half period of 50 ns
    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;
    end

endmodule

// ==== lsu_assert.sv ====
// protocol checks on the lsu_top ports; checks are idle while rst_n is low
`timescale 1ns/1ps

module lsu_assert (
    input logic                clk,
    input logic                rst_n,
    input logic                req_valid_i,
    input logic                stall_o,
    input logic                wb_valid_o,
    input lsu_pkg::lsu_wb_t    wb_o,
    input logic                wb_ready_i,
    input logic                ar_valid_o,
    input lsu_pkg::axi_addr_t  ar_o,
    input logic                ar_ready_i,
    input logic                aw_valid_o,
    input lsu_pkg::axi_addr_t  aw_o,
    input logic                aw_ready_i,
    input logic                w_valid_o,
    input lsu_pkg::axi_wdata_t w_o,
    input logic                w_ready_i,
    input lsu_pkg::slot_vec_t  slot_valid_i
);

    // held valids keep their payload until the handshake
    ar_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
        ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o))
        else $error("AR valid dropped or payload changed before ar_ready_i");

    aw_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
        aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_o))
        else $error("AW valid dropped or payload changed before aw_ready_i");

    w_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
        w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_o))
        else $error("W valid dropped or payload changed before w_ready_i");

    wb_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid_o && !wb_ready_i |=> wb_valid_o && $stable(wb_o))
        else $error("write-back valid dropped or payload changed before wb_ready_i");

    // stall follows the slot valid bits, not only the counter
    stall_full_a: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid_i |-> (stall_o == (&slot_valid_i)))
        else $error("stall_o disagrees with the queue slot occupancy");

endmodule

bind lsu_top lsu_assert lsu_assert_inst (.*, .slot_valid_i(slot_valid));

// ==== tb_lsu.sv ====
// lsu_top testbench; memory model holds 64 words, so address bits above 7 alias
`timescale 1ns/1ps

module tb_lsu;

    logic                clk, rst_n;
    logic                req_valid_i, stall_o, busy_o, wb_valid_o, wb_ready_i;
    lsu_pkg::lsu_req_t   req_i;
    lsu_pkg::lsu_wb_t    wb_o;
    logic                ar_valid_o, ar_ready_i, r_valid_i, r_ready_o;
    logic                aw_valid_o, aw_ready_i, w_valid_o, w_ready_i, b_valid_i, b_ready_o;
    lsu_pkg::axi_addr_t  ar_o, aw_o;
    lsu_pkg::axi_wdata_t w_o;
    lsu_pkg::word_t      r_data_i, r_addr, aw_addr;

    lsu_pkg::word_t      mem    [64];
    lsu_pkg::word_t      shadow [64];
    lsu_pkg::lsu_wb_t    expect_q [$];
    lsu_pkg::axi_addr_t  ar_expect_q [$];
    lsu_pkg::axi_addr_t  aw_expect_q [$];
    logic [31:0]         bus_lfsr, stim_lfsr;
    logic                r_pend, b_pend, ar_hold, wb_throttle, stall_seen;
    logic [3:0]          next_id;
    int                  errors, test_errs, checks, issued, cycles;

    lsu_tb_clk clk_gen_inst (.clk_o(clk));

    lsu_top lsu_top_inst (.*);

    // ========================================================================
    // random source and reference model
    // ========================================================================
    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(inout logic [31:0] st, input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            st = lfsr_step(st);
            v  = {v[30:0], st[0]};
        end
    endtask

    // shift the addressed lane down, then extend
    function automatic lsu_pkg::word_t ref_load(lsu_pkg::mem_op_e kind, lsu_pkg::word_t addr);
        lsu_pkg::word_t w;
        w = shadow[addr[7:2]] >> (8 * addr[1:0]);
        case (kind)
            lsu_pkg::LB:  return lsu_pkg::word_t'($signed(w[7:0]));
            lsu_pkg::LBU: return {24'h0, w[7:0]};
            lsu_pkg::LH:  return lsu_pkg::word_t'($signed(w[15:0]));
            lsu_pkg::LHU: return {16'h0, w[15:0]};
            default:      return w;
        endcase
    endfunction

    // bus size code from the access width in bytes
    function automatic logic [2:0] size_of(lsu_pkg::mem_op_e kind);
        case (kind)
            lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH: return 3'd1;
            lsu_pkg::LW, lsu_pkg::SW:               return 3'd2;
            default:                                return 3'd0;
        endcase
    endfunction

    task automatic check_wb(input lsu_pkg::lsu_wb_t exp, input lsu_pkg::lsu_wb_t got);
        checks++;
        if (got !== exp) begin
            $display("Error: wb_o expected %h got %h", exp, got);
            errors++;
            test_errs++;
        end
    endtask

    task automatic check_word(input string name, input lsu_pkg::word_t exp,
                              input lsu_pkg::word_t got);
        checks++;
        if (got !== exp) begin
            $display("Error: %s expected %h got %h", name, exp, got);
            errors++;
            test_errs++;
        end
    endtask

    task automatic check_addr(input string name, input lsu_pkg::axi_addr_t exp,
                              input lsu_pkg::axi_addr_t got);
        checks++;
        if (got !== exp) begin
            $display("Error: %s expected %h got %h", name, exp, got);
            errors++;
            test_errs++;
        end
    endtask

    // ========================================================================
    // request driving
    // ========================================================================
    task automatic send(input lsu_pkg::lsu_req_t r);
        req_i       = r;
        req_valid_i = 1'b1;
        issued++;
        @(posedge clk);
        while (stall_o) @(posedge clk);
        #1;
        req_valid_i = 1'b0;
    endtask

    task automatic do_load(input lsu_pkg::mem_op_e kind, input lsu_pkg::word_t addr);
        lsu_pkg::lsu_req_t  r;
        lsu_pkg::lsu_wb_t   e;
        lsu_pkg::axi_addr_t a;
        r = '{op: kind, addr: addr, wdata: '0, wmask: '0, rd: {1'b1, next_id},
              commit_id: next_id, reg_we: 1'b1};
        e = '{data: ref_load(kind, addr), rd: r.rd, commit_id: next_id, reg_we: 1'b1};
        a = '{addr: addr, size: size_of(kind)};
        expect_q.push_back(e);
        ar_expect_q.push_back(a);
        next_id++;
        send(r);
    endtask

    // data is replicated over all lanes so the masked lane carries it
    task automatic do_store(input lsu_pkg::mem_op_e kind, input lsu_pkg::word_t addr,
                            input lsu_pkg::word_t val);
        lsu_pkg::lsu_req_t  r;
        lsu_pkg::strb_t     m;
        lsu_pkg::word_t     d;
        lsu_pkg::axi_addr_t a;
        m = 4'b1111;
        d = val;
        if (kind == lsu_pkg::SB) begin
            m = 4'b0001 << addr[1:0];
            d = {4{val[7:0]}};
        end else if (kind == lsu_pkg::SH) begin
            m = 4'b0011 << addr[1:0];
            d = {2{val[15:0]}};
        end
        for (int b = 0; b < 4; b++) begin
            if (m[b]) shadow[addr[7:2]][8*b +: 8] = d[8*b +: 8];
        end
        r = '{op: kind, addr: addr, wdata: d, wmask: m, rd: '0,
              commit_id: next_id, reg_we: 1'b0};
        a = '{addr: addr, size: size_of(kind)};
        aw_expect_q.push_back(a);
        next_id++;
        send(r);
    endtask

    // queue and busy are sampled away from the active edge
    task automatic end_test(input string name);
        @(negedge clk);
        while (expect_q.size() != 0 || busy_o) @(negedge clk);
        @(posedge clk);
        #1;
        // forwarded loads never reach the read channel
        ar_expect_q.delete();
        $display("test %s %s, %0d errors", name, (test_errs == 0) ? "ok" : "failed",
                 test_errs);
        test_errs = 0;
    endtask

    // ========================================================================
    // AXI memory model and write-back compare
    // ========================================================================
    always @(posedge clk) begin : bus_model
        logic [31:0] rb;
        if (rst_n) begin
            if (r_valid_i && r_ready_o) r_pend = 1'b0;
            if (ar_valid_o && ar_ready_i) begin
                r_pend = 1'b1;
                r_addr = ar_o.addr;
                if (ar_expect_q.size() == 0) begin
                    $display("read address issued with no load waiting for it");
                    errors++;
                    test_errs++;
                end else begin
                    check_addr("ar_o", ar_expect_q.pop_front(), ar_o);
                end
            end
            if (b_valid_i && b_ready_o) b_pend = 1'b0;
            if (aw_valid_o && aw_ready_i) begin
                aw_addr = aw_o.addr;
                if (aw_expect_q.size() == 0) begin
                    $display("write address issued with no store waiting for it");
                    errors++;
                    test_errs++;
                end else begin
                    check_addr("aw_o", aw_expect_q.pop_front(), aw_o);
                end
            end
            if (w_valid_o && w_ready_i) begin
                for (int b = 0; b < 4; b++) begin
                    if (w_o.strb[b]) mem[aw_addr[7:2]][8*b +: 8] = w_o.data[8*b +: 8];
                end
                b_pend = 1'b1;
            end
            if (stall_o) stall_seen = 1'b1;
        end
        #1;
        take_bits(bus_lfsr, 4, rb);
        ar_ready_i = rb[0] && !ar_hold;
        aw_ready_i = rb[1];
        w_ready_i  = rb[2];
        wb_ready_i = wb_throttle ? rb[3] : 1'b1;
        r_valid_i  = r_pend;
        r_data_i   = mem[r_addr[7:2]];
        b_valid_i  = b_pend;
    end

    always @(posedge clk) begin : wb_compare
        if (rst_n && wb_valid_o && wb_ready_i) begin
            if (expect_q.size() == 0) begin
                $display("write-back with id %h arrived with nothing expected", wb_o.commit_id);
                errors++;
                test_errs++;
            end else begin
                check_wb(expect_q.pop_front(), wb_o);
            end
        end
    end

    // budget of 40 cycles per request plus reset margin
    initial begin : watchdog
        cycles = 0;
        while (cycles <= 40 * issued + 100) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles with %0d requests issued", cycles, issued);
        $display("TEST FAIL");
        $finish;
    end

    // ========================================================================
    // tests
    // ========================================================================
    initial begin
        logic [31:0]      rv;
        lsu_pkg::mem_op_e kind;
        lsu_pkg::word_t   addr;
        rst_n       = 1'b0;
        req_valid_i = 1'b0;
        req_i       = '0;
        wb_ready_i  = 1'b0;
        ar_ready_i  = 1'b0;
        aw_ready_i  = 1'b0;
        w_ready_i   = 1'b0;
        r_valid_i   = 1'b0;
        b_valid_i   = 1'b0;
        r_data_i    = '0;
        r_addr      = '0;
        aw_addr     = '0;
        r_pend      = 1'b0;
        b_pend      = 1'b0;
        ar_hold     = 1'b0;
        wb_throttle = 1'b0;
        stall_seen  = 1'b0;
        next_id     = '0;
        bus_lfsr    = 32'h54c6_0b69;
        stim_lfsr   = 32'h54c6_0b69;
        for (int i = 0; i < 64; i++) begin
            mem[i]    = ((32'(i) + 32'd1) * 32'h0104_0b17) ^ 32'h8080_8080;
            shadow[i] = mem[i];
        end
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // every load kind at every legal offset of two words
        for (int w = 4; w < 6; w++) begin
            for (int o = 0; o < 4; o++) begin
                addr = lsu_pkg::word_t'(4 * w + o);
                do_load(lsu_pkg::LB, addr);
                do_load(lsu_pkg::LBU, addr);
                if (o % 2 == 0) begin
                    do_load(lsu_pkg::LH, addr);
                    do_load(lsu_pkg::LHU, addr);
                end
                if (o == 0) do_load(lsu_pkg::LW, addr);
            end
        end
        end_test("load kinds");

        // partial stores merge into the word
        for (int o = 0; o < 4; o++) begin
            take_bits(stim_lfsr, 8, rv);
            do_store(lsu_pkg::SB, lsu_pkg::word_t'(40 + o), rv);
        end
        for (int o = 0; o < 4; o += 2) begin
            take_bits(stim_lfsr, 16, rv);
            do_store(lsu_pkg::SH, lsu_pkg::word_t'(44 + o), rv);
        end
        do_load(lsu_pkg::LW, 32'd40);
        do_load(lsu_pkg::LW, 32'd44);
        end_test("sub-word");
        for (int i = 0; i < 64; i++) begin
            check_word($sformatf("mem[%0d]", i), shadow[i], mem[i]);
        end
        end_test("memory dump");

        // loads right behind a full-word store
        for (int k = 0; k < 3; k++) begin
            take_bits(stim_lfsr, 32, rv);
            addr = lsu_pkg::word_t'(80 + 4 * k);
            do_store(lsu_pkg::SW, addr, rv);
            do_load(lsu_pkg::LB, addr);
            do_load(lsu_pkg::LHU, addr);
            do_load(lsu_pkg::LW, addr);
        end
        end_test("forwarding");

        // random loads against a throttled consumer
        wb_throttle = 1'b1;
        for (int k = 0; k < 24; k++) begin
            take_bits(stim_lfsr, 11, rv);
            kind = (rv[10:8] > 3'd4) ? lsu_pkg::LW : lsu_pkg::mem_op_e'(rv[10:8]);
            addr = {24'h0, rv[7:0]};
            if (kind == lsu_pkg::LW) addr[1:0] = 2'b00;
            if (kind inside {lsu_pkg::LH, lsu_pkg::LHU}) addr[0] = 1'b0;
            do_load(kind, addr);
        end
        end_test("wb stall");
        wb_throttle = 1'b0;

        // AR held off until the queue has filled
        ar_hold    = 1'b1;
        stall_seen = 1'b0;
        fork
            for (int k = 0; k < 12; k++) begin
                do_load(lsu_pkg::LW, lsu_pkg::word_t'(4 * k));
            end
            begin
                repeat (30) @(posedge clk);
                @(negedge clk);
                ar_hold = 1'b0;
            end
        join
        if (!stall_seen) begin
            $display("stall_o never rose while AR was held and the queue was full");
            errors++;
            test_errs++;
        end
        end_test("queue full");

        $display("tests 6, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== src.f ====
lsu_pkg.sv
lsu_load_align.sv
lsu_slot_store.sv
lsu_fwd_match.sv
lsu_ctrl.sv
lsu_top.sv
lsu_tb_clk.sv
lsu_assert.sv
tb_lsu.sv

// ==== Makefile ====
# Verilator flow for the LSU testbench
TOP := tb_lsu

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f src.f -o V$(TOP)

# the log decides the result
run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "TEST FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log
